//--- sources.f
+incdir+common
common/simonPkg.sv
source/simonRound.sv
source/simonKeyStep.sv
simonEngine/simonEngine.sv
source/simonTop.sv
dv/simonEngine_chk.sv
dv/simonTb.sv

//--- Bender.yml
package:
  name: simon_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/simonPkg.sv
      - source/simonRound.sv
      - source/simonKeyStep.sv
      - simonEngine/simonEngine.sv
      - source/simonTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/simonEngine_chk.sv
      - dv/simonTb.sv

//--- dv/simonTb.sv
module simonTb;

	timeunit 1ns;
	timeprecision 1ps;

	import simonPkg::*;

	localparam int jobLimit = 60;
	// z0 in natural order, first constant bit on the left
	localparam logic [61:0] z0 = 62'b11111010001001010110000111001101111101000100101011000011100110;

	logic clkAll;
	logic nR;
	logic newData;
	logic newKey;
	logic encDec;
	logic readData;
	blockT plain;
	keyT key;
	logic ldData;
	logic ldKey;
	logic doneData;
	logic doneKey;
	blockT cipher;

	logic [31:0] lfsr;
	logic [15:0] rk [32]; // model round keys
	int valueErrors = 0;
	int otherErrors = 0;

	simonTop dut0
	(
		.clkAll(clkAll),
		.nR(nR),
		.newData(newData),
		.newKey(newKey),
		.encDec(encDec),
		.readData(readData),
		.plain(plain),
		.key(key),
		.ldData(ldData),
		.ldKey(ldKey),
		.doneData(doneData),
		.doneKey(doneKey),
		.cipher(cipher)
	);

	always #4 clkAll = ~clkAll;

	// galois lfsr, one step per bit
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [15:0] rol16(input logic [15:0] x, input int s);
		return (x << s) | (x >> (16 - s));
	endfunction

	function automatic logic [15:0] mixF(input logic [15:0] x);
		return (rol16(x, 1) & rol16(x, 8)) ^ rol16(x, 2);
	endfunction

	task automatic expandKey(input logic [63:0] k);
		logic [15:0] tmp;
		for (int i = 0; i < 4; i++)
			rk[i] = k[16*i +: 16];
		for (int i = 4; i < 32; i++)
		begin
			tmp = rol16(rk[i-1], 13) ^ rk[i-3]; // ror by 3
			tmp = tmp ^ rol16(tmp, 15);
			rk[i] = 16'hfffc ^ {15'b0, z0[61-(i-4)]} ^ rk[i-4] ^ tmp;
		end
	endtask

	function automatic logic [31:0] modelEncrypt(input logic [31:0] pt);
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] tmp;
		x = pt[31:16];
		y = pt[15:0];
		for (int i = 0; i < 32; i++)
		begin
			tmp = x;
			x = y ^ mixF(x) ^ rk[i];
			y = tmp;
		end
		return {x, y};
	endfunction

	function automatic logic [31:0] modelDecrypt(input logic [31:0] ct);
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] tmp;
		x = ct[31:16];
		y = ct[15:0];
		for (int i = 31; i >= 0; i--)
		begin
			tmp = y;
			y = x ^ mixF(y) ^ rk[i];
			x = tmp;
		end
		return {x, y};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic finishRun();
		$display("value errors: %0d, other errors: %0d, assertion failures: %0d",
			valueErrors, otherErrors, dut0.engine0.chk0.assertFails);
		if (valueErrors == 0 && otherErrors == 0 && dut0.engine0.chk0.assertFails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	task automatic failTimeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		otherErrors++;
		finishRun();
	endtask

	// request a job, wait for its result, leave it unread
	task automatic runJob(input logic [31:0] pt, input logic enc, input logic withKey,
		input logic [63:0] k, output logic [31:0] result);
		int edges;
		int acceptEdge;
		plain = pt;
		encDec = enc;
		key = k;
		newData = 1'b1;
		newKey = withKey;
		if (withKey)
			expandKey(k);
		edges = 0;
		while (!ldData && edges < jobLimit)
		begin
			@(posedge clkAll);
			#1;
			edges++;
		end
		if (!ldData)
			failTimeout("ldData never rose after a load request");
		acceptEdge = edges - 1; // ldData rises one edge after acceptance
		newData = 1'b0;
		newKey = 1'b0;
		if (withKey)
		begin
			checkValue("ldKey", ldKey, 1);
			checkValue("doneKey", doneKey, 0);
		end
		else
			checkValue("ldKey", ldKey, 0);
		while (!doneData && edges < acceptEdge + jobLimit)
		begin
			@(posedge clkAll);
			#1;
			edges++;
		end
		if (!doneData)
			failTimeout("doneData never rose after a job started");
		checkValue("doneData latency", edges - acceptEdge, 33);
		checkValue("ldData", ldData, 0);
		if (withKey)
		begin
			checkValue("doneKey", doneKey, 1);
			checkValue("ldKey", ldKey, 0);
		end
		result = cipher;
	endtask

	task automatic ackResult();
		int n;
		readData = 1'b1;
		@(posedge clkAll);
		#1;
		readData = 1'b0;
		n = 0;
		while (doneData && n < 10)
		begin
			@(posedge clkAll);
			#1;
			n++;
		end
		if (doneData)
			failTimeout("doneData stayed high after readData");
	endtask

	initial
	begin
		logic [31:0] pt;
		logic [31:0] nextPt;
		logic [31:0] got;
		logic [31:0] back;
		logic [31:0] held;
		logic [63:0] curKey;
		int hold;
		lfsr = 32'h42da;
		clkAll = 1'b0;
		nR = 1'b0;
		newData = 1'b0;
		newKey = 1'b0;
		encDec = 1'b1;
		readData = 1'b0;
		plain = '0;
		key = '0;
		repeat (4) @(posedge clkAll);
		#1;
		nR = 1'b1;
		checkValue("ldData", ldData, 0);
		checkValue("ldKey", ldKey, 0);
		checkValue("doneData", doneData, 0);
		checkValue("doneKey", doneKey, 0);
		checkValue("cipher", cipher, 0);

		// decrypt without a key schedule must be ignored
		newData = 1'b1;
		encDec = 1'b0;
		for (int c = 0; c < 40; c++)
		begin
			@(posedge clkAll);
			#1;
			checkValue("ldData", ldData, 0);
		end

		curKey = {16'h1918, 16'h1110, 16'h0908, 16'h0100};
		runJob(32'h65656877, 1'b1, 1'b1, curKey, got);
		checkValue("cipher", got, 32'hc69be9bb);
		checkValue("model cipher", modelEncrypt(32'h65656877), 32'hc69be9bb);
		ackResult();

		for (int j = 0; j < 30; j++)
		begin
			curKey = randBits(64);
			pt = randBits(32);
			runJob(pt, 1'b1, 1'b1, curKey, got);
			checkValue("cipher", got, modelEncrypt(pt));
			ackResult();
		end

		for (int j = 0; j < 10; j++)
		begin
			pt = randBits(32);
			runJob(pt, 1'b0, 1'b0, curKey, got);
			checkValue("cipher", got, modelDecrypt(pt));
			ackResult();
			runJob(got, 1'b1, 1'b0, curKey, back); // round trip
			checkValue("cipher", back, pt);
			ackResult();
		end

		// hold off readData with the next request already pending
		pt = randBits(32);
		for (int j = 0; j < 5; j++)
		begin
			runJob(pt, 1'b1, 1'b0, curKey, got);
			checkValue("cipher", got, modelEncrypt(pt));
			held = cipher;
			hold = randBits(5) % 21;
			nextPt = randBits(32);
			plain = nextPt;
			encDec = 1'b1;
			newData = (j < 4);
			for (int c = 0; c < hold; c++)
			begin
				@(posedge clkAll);
				#1;
				checkValue("cipher", cipher, held);
				checkValue("doneData", doneData, 1);
				checkValue("ldData", ldData, 0);
			end
			ackResult();
			pt = nextPt;
		end
		newData = 1'b0;
		finishRun();
	end

endmodule

//--- dv/simonEngine_chk.sv
module simonEngineChk
(
	input logic clkAll,
	input logic nR,
	input logic readData,
	input logic ldData,
	input logic doneData,
	input logic doneKey,
	input logic goData,
	input logic encMode,
	input simonPkg::blockT cipher
);

	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0; // summed into the testbench's closing line

	doneNeedsRead: assert property (@(posedge clkAll) disable iff (!nR)
		$fell(doneData) |-> $past(readData))
	else
	begin
		assertFails++;
		$error("doneData fell without readData");
	end

	cipherHeld: assert property (@(posedge clkAll) disable iff (!nR)
		doneData |=> $stable(cipher))
	else
	begin
		assertFails++;
		$error("cipher changed while doneData was high");
	end

	noOverlap: assert property (@(posedge clkAll) disable iff (!nR)
		!(ldData && doneData))
	else
	begin
		assertFails++;
		$error("ldData and doneData both high");
	end

	// goData rises on the edge after acceptance
	decNeedsKey: assert property (@(posedge clkAll) disable iff (!nR)
		$rose(goData) && !encMode |-> $past(doneKey))
	else
	begin
		assertFails++;
		$error("decrypt accepted without a finished key schedule");
	end

endmodule

bind simonEngine simonEngineChk chk0
(
	.clkAll(clkAll),
	.nR(nR),
	.readData(readData),
	.ldData(ldData),
	.doneData(doneData),
	.doneKey(doneKey),
	.goData(goData),
	.encMode(encMode),
	.cipher(cipher)
);

//--- source/simonTop.sv
module simonTop
(
	input logic clkAll,
	input logic nR,
	input logic newData,
	input logic newKey,
	input logic encDec,
	input logic readData,
	input simonPkg::blockT plain,
	input simonPkg::keyT key,
	output logic ldData,
	output logic ldKey,
	output logic doneData,
	output logic doneKey,
	output simonPkg::blockT cipher
);

	import simonPkg::*;

	keyT keyWin; // four newest key words
	roundT count;
	wordT nextKey;

	simonEngine engine0
	(
		.clkAll(clkAll),
		.nR(nR),
		.newData(newData),
		.newKey(newKey),
		.encDec(encDec),
		.readData(readData),
		.plain(plain),
		.key(key),
		.nextKey(nextKey),
		.ldData(ldData),
		.ldKey(ldKey),
		.doneData(doneData),
		.doneKey(doneKey),
		.cipher(cipher),
		.keyWin(keyWin),
		.count(count)
	);

	// key step runs beside the engine, purely combinational
	simonKeyStep keyStep0
	(
		.keyWin(keyWin),
		.count(count),
		.nextKey(nextKey)
	);

endmodule

//--- simonEngine/simonEngine.sv
`include "simon_defs.svh"

module simonEngine
(
	input logic clkAll,
	input logic nR,
	input logic newData,
	input logic newKey,
	input logic encDec,
	input logic readData,
	input simonPkg::blockT plain,
	input simonPkg::keyT key,
	input simonPkg::wordT nextKey,
	output logic ldData,
	output logic ldKey,
	output logic doneData,
	output logic doneKey,
	output simonPkg::blockT cipher,
	output simonPkg::keyT keyWin,
	output simonPkg::roundT count
);

	import simonPkg::*;

	engineStateT state;
	engineStateT stateNext;

	logic goData; // request latched in stLoad, job starts next edge
	logic goKey;
	logic encMode;
	logic acceptData;
	logic acceptKey;
	logic lastRound;
	logic keyStepOn;

	wordT keyStore [`SIMON_T];
	wordT roundKey;
	roundT revIdx;
	roundT keyIdx;
	blockT blockReg;
	blockT roundOut;

	function automatic blockT swapHalves(input blockT b);
		return {b[0], b[1]};
	endfunction

	// decrypt only runs on a finished schedule
	always_comb
	begin
		acceptKey = newKey;
		if (encDec)
			acceptData = newData && (newKey || doneKey);
		else
			acceptData = newData && doneKey;
	end

	assign lastRound = (count == roundT'(`SIMON_T - 2));
	assign revIdx = roundT'(`SIMON_T - 1) - count;
	assign keyIdx = count + roundT'(`SIMON_M);
	assign keyStepOn = ldKey && (count < roundT'(`SIMON_T - `SIMON_M));

	assign roundKey = encMode ? keyStore[count] : keyStore[revIdx];

	simonRound round0
	(
		.block(blockReg),
		.roundKey(roundKey),
		.next(roundOut)
	);

	always_comb
	begin
		case (state)
			stIdle:
			begin
				stateNext = stLoad;
			end
			stLoad:
			begin
				if (goData || goKey)
					stateNext = stExecute;
				else
					stateNext = stLoad;
			end
			stExecute:
			begin
				if (lastRound)
					stateNext = stWrite;
				else
					stateNext = stExecute;
			end
			stWrite:
			begin
				// hold here until the host has taken the result
				if (ldData || ldKey || doneData || readData)
					stateNext = stWrite;
				else
					stateNext = stLoad;
			end
			default:
			begin
				stateNext = stIdle;
			end
		endcase
	end

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
		begin
			state <= stIdle;
			count <= '0;
		end
		else
		begin
			state <= stateNext;
			if (state == stExecute)
				count <= count + roundT'(1);
			else if (state != stWrite)
				count <= '0; // count holds 31 through stWrite
		end
	end

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
		begin
			goData <= 1'b0;
			goKey <= 1'b0;
			encMode <= 1'b1;
			ldData <= 1'b0;
			ldKey <= 1'b0;
			doneData <= 1'b0;
			doneKey <= 1'b0;
		end
		else
		begin
			if (readData)
				doneData <= 1'b0;
			case (state)
				stIdle:
				begin
					goData <= 1'b0;
					goKey <= 1'b0;
				end
				stLoad:
				begin
					if (goData || goKey)
					begin
						ldData <= goData;
						ldKey <= goKey;
						goData <= 1'b0;
						goKey <= 1'b0;
					end
					else
					begin
						goData <= acceptData;
						goKey <= acceptKey;
						if (acceptData)
							encMode <= encDec;
						if (acceptKey)
							doneKey <= 1'b0; // old schedule is being replaced
					end
				end
				stWrite:
				begin
					if (ldData)
					begin
						ldData <= 1'b0;
						doneData <= 1'b1;
					end
					if (ldKey)
					begin
						ldKey <= 1'b0;
						doneKey <= 1'b1;
					end
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clkAll, negedge nR)
	begin
		if (!nR)
			cipher <= '0;
		else if ((state == stWrite) && ldData)
			cipher <= encMode ? roundOut : swapHalves(roundOut); // last round applied here
	end

	// block register, swapped on the way in for decryption
	always_ff @(posedge clkAll)
	begin
		if ((state == stLoad) && !(goData || goKey) && acceptData)
			blockReg <= encDec ? plain : swapHalves(plain);
		else if ((state == stExecute) && ldData)
			blockReg <= roundOut;
	end

	always_ff @(posedge clkAll)
	begin
		if ((state == stLoad) && !(goData || goKey) && acceptKey)
		begin
			for (int i = 0; i < `SIMON_M; i++)
				keyStore[i] <= key[i];
			keyWin <= key;
		end
		else if ((state == stExecute) && keyStepOn)
		begin
			keyStore[keyIdx] <= nextKey; // always ahead of the round that reads it
			keyWin <= {nextKey, keyWin[`SIMON_M-1:1]};
		end
	end

endmodule

//--- source/simonKeyStep.sv
`include "simon_defs.svh"

module simonKeyStep
(
	input simonPkg::keyT keyWin,
	input simonPkg::roundT count,
	output simonPkg::wordT nextKey
);

	import simonPkg::*;

	localparam zSeq = `SIMON_Z0;
	localparam wordT roundConst = wordT'(3);

	wordT rot3;
	wordT mixA;
	wordT mixB;
	wordT zWord;
	logic zBit;

	function automatic wordT ror(input wordT x, input int s);
		return (x >> s) | (x << (`SIMON_N - s));
	endfunction

	// newest key word sits at the top of the window
	assign rot3 = ror(keyWin[`SIMON_M-1], 3);
	assign mixA = rot3 ^ keyWin[1];
	assign mixB = mixA ^ ror(mixA, 1);

	assign zBit = zSeq[count]; // one constant bit per key step
	assign zWord = {{(`SIMON_N-1){1'b0}}, zBit};

	// ~k0 ^ 3 is the usual c ^ k0 with c = 0xfffc
	assign nextKey = ~keyWin[0] ^ mixB ^ zWord ^ roundConst;

endmodule

//--- source/simonRound.sv
`include "simon_defs.svh"

module simonRound
(
	input simonPkg::blockT block,
	input simonPkg::wordT roundKey,
	output simonPkg::blockT next
);

	import simonPkg::*;

	wordT left;
	wordT right;
	wordT mix;

	function automatic wordT rol(input wordT x, input int s);
		return (x << s) | (x >> (`SIMON_N - s));
	endfunction

	assign left = block[1];
	assign right = block[0];

	// nonlinear part of the Feistel step
	assign mix = (rol(left, 1) & rol(left, 8)) ^ rol(left, 2);

	assign next[1] = right ^ roundKey ^ mix;
	assign next[0] = left; // old left moves right

endmodule

//--- common/simonPkg.sv
`include "simon_defs.svh"

package simonPkg;

	typedef logic [`SIMON_N-1:0] wordT;

	// index 1 is the left half
	typedef wordT [1:0] blockT;

	typedef wordT [`SIMON_M-1:0] keyT; // word 0 is the first round key

	typedef logic [`SIMON_CW-1:0] roundT;

	typedef enum logic [1:0]
	{
		stIdle,
		stLoad,
		stExecute,
		stWrite
	} engineStateT;

endpackage

//--- common/simon_defs.svh
`ifndef SIMON_DEFS_SVH
`define SIMON_DEFS_SVH

// word size in bits
`define SIMON_N 16

// key words for the 64-bit key
`define SIMON_M 4

`define SIMON_T 32 // rounds per block
`define SIMON_CW 5 // wide enough for count 0..31

// z0 sequence, bit 0 is the constant for the first key step
`define SIMON_Z0 62'b0110011100001101010010001011111_0110011100001101010010001011111

`endif
